/* all.f */
+incdir+hdl
hdl/i2c_pkg.sv
hdl/i2c_tick_gen.sv
hdl/i2c_bit_engine.sv
hdl/i2c_txn_sequencer.sv
hdl/i2c_master_top.sv
tests/i2c_slave_model.sv
tests/i2c_master_sva.sv
tests/tb_i2c_master.sv

/* hdl/i2c_bit_engine.sv */
`timescale 1ns/1ps
`include "i2c_params.svh"

module i2c_bit_engine
    import i2c_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_tick,
    input  logic     i_cmd_valid,
    input  i2c_cmd_e i_cmd,
    input  logic     i_tx_bit,
    input  logic     i_scl_in,
    input  logic     i_sda_in,
    output logic     o_done,
    output logic     o_rx_bit,
    output logic     o_scl_low,
    output logic     o_sda_low
);

    localparam int PH_W = $clog2(`I2C_PHASES);

    logic            active;
    logic [PH_W-1:0] phase;
    i2c_cmd_e        cmd_q;

    logic is_start;
    assign is_start = (cmd_q == CMD_START) || (cmd_q == CMD_RESTART);

    // ============================================================
    // phase sequencing
    // ============================================================
    // accept:  SDA is set up while SCL is still low
    // phase 0: release SCL
    // phase 1: wait for SCL high, repeats while a slave stretches
    // phase 2: sample SDA and pull SCL low, or move SDA for start / stop
    // phase 3: finish, a start also pulls SCL low here
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            active    <= 1'b0;
            phase     <= '0;
            cmd_q     <= CMD_START;
            o_done    <= 1'b0;
            o_rx_bit  <= 1'b0;
            o_scl_low <= 1'b0;
            o_sda_low <= 1'b0;
        end else begin
            o_done <= 1'b0;

            if (!active) begin
                if (i_cmd_valid) begin
                    active <= 1'b1;
                    phase  <= '0;
                    cmd_q  <= i_cmd;
                    case (i_cmd)
                        CMD_WRITE_BIT: o_sda_low <= ~i_tx_bit;
                        CMD_STOP:      o_sda_low <= 1'b1; // low before SCL rises
                        default:       o_sda_low <= 1'b0; // start, restart, read
                    endcase
                end
            end else if (i_tick) begin
                case (phase)
                    0: begin
                        o_scl_low <= 1'b0;
                        phase     <= phase + 1'b1;
                    end

                    1: begin
                        if (i_scl_in) begin
                            phase <= phase + 1'b1;
                        end
                    end

                    2: begin
                        case (cmd_q)
                            CMD_START, CMD_RESTART: begin
                                o_sda_low <= 1'b1; // start condition
                            end
                            CMD_STOP: begin
                                o_sda_low <= 1'b0; // stop condition
                            end
                            default: begin
                                o_rx_bit  <= i_sda_in;
                                o_scl_low <= 1'b1;
                            end
                        endcase
                        phase <= phase + 1'b1;
                    end

                    default: begin
                        if (is_start) begin
                            o_scl_low <= 1'b1;
                        end
                        active <= 1'b0;
                        phase  <= '0;
                        o_done <= 1'b1;
                    end
                endcase
            end
        end
    end

    // after an aborted transfer SCL stays low until the next start

endmodule

/* hdl/i2c_master_top.sv */
`timescale 1ns/1ps
`include "i2c_params.svh"

module i2c_master_top
    import i2c_pkg::*;
(
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_enable,
    input  logic                       i_rw,
    input  logic [`I2C_ADDR_WIDTH-1:0] i_device_addr,
    input  logic [`I2C_BYTE_WIDTH-1:0] i_reg_addr,
    input  logic [`I2C_BYTE_WIDTH-1:0] i_mosi_data,
    input  logic [`I2C_DIV_WIDTH-1:0]  i_divider,
    output logic [`I2C_BYTE_WIDTH-1:0] o_miso_data,
    output logic                       o_busy,
    inout  wire                        io_scl,
    inout  wire                        io_sda
);

    logic     tick;
    logic     cmd_valid;
    i2c_cmd_e cmd;
    logic     tx_bit;
    logic     done;
    logic     rx_bit;
    logic     scl_low;
    logic     sda_low;

    // ============================================================
    // open-drain pads, pulled up outside
    // ============================================================
    assign io_scl = scl_low ? 1'b0 : 1'bz;
    assign io_sda = sda_low ? 1'b0 : 1'bz;

    i2c_tick_gen u_tick (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_divider (i_divider),
        .o_tick    (tick)
    );

    i2c_txn_sequencer u_seq (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_tick        (tick),
        .i_enable      (i_enable),
        .i_rw          (i_rw),
        .i_device_addr (i_device_addr),
        .i_reg_addr    (i_reg_addr),
        .i_mosi_data   (i_mosi_data),
        .i_done        (done),
        .i_rx_bit      (rx_bit),
        .o_cmd_valid   (cmd_valid),
        .o_cmd         (cmd),
        .o_tx_bit      (tx_bit),
        .o_miso_data   (o_miso_data),
        .o_busy        (o_busy)
    );

    i2c_bit_engine u_bit (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_tick      (tick),
        .i_cmd_valid (cmd_valid),
        .i_cmd       (cmd),
        .i_tx_bit    (tx_bit),
        .i_scl_in    (io_scl),  // resolved line, sees stretching
        .i_sda_in    (io_sda),
        .o_done      (done),
        .o_rx_bit    (rx_bit),
        .o_scl_low   (scl_low),
        .o_sda_low   (sda_low)
    );

endmodule

/* hdl/i2c_params.svh */
`ifndef I2C_PARAMS_SVH
`define I2C_PARAMS_SVH

// ============================================================
// bus timing
// ============================================================

// divider value and counter width
`define I2C_DIV_WIDTH 16

// divider ticks per bus phase
`define I2C_PHASES 4

// ============================================================
// field widths
// ============================================================

`define I2C_ADDR_WIDTH 7 // 7-bit device address
`define I2C_BYTE_WIDTH 8 // register address, data and bus byte

`endif

/* hdl/i2c_pkg.sv */
`include "i2c_params.svh"

package i2c_pkg;

    // ============================================================
    // bus phase requested from the bit engine
    // ============================================================
    typedef enum logic [2:0] {
        CMD_START,
        CMD_RESTART,
        CMD_STOP,
        CMD_WRITE_BIT,
        CMD_READ_BIT
    } i2c_cmd_e;

    // ============================================================
    // transaction states of the sequencer
    // ============================================================
    typedef enum logic [3:0] {
        IDLE,
        START,
        DEV_W,   // address + write
        REG,     // register address
        RESTART,
        DEV_R,   // address + read
        WDATA,
        RDATA,   // read byte, then nack
        ACK,
        STOP
    } i2c_txn_state_e;

    // first byte after a start, shifted raw or read as fields
    typedef union packed {
        logic [`I2C_BYTE_WIDTH-1:0] raw;
        struct packed {
            logic [`I2C_ADDR_WIDTH-1:0] dev_addr;
            logic                       rw; // 1 = read
        } f;
    } i2c_addr_byte_u;

endpackage

/* hdl/i2c_tick_gen.sv */
`timescale 1ns/1ps
`include "i2c_params.svh"

module i2c_tick_gen (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic [`I2C_DIV_WIDTH-1:0] i_divider,
    output logic                      o_tick
);

    logic [`I2C_DIV_WIDTH-1:0] count;

    // >= so a divider lowered on the fly still wraps at once
    assign o_tick = (count >= i_divider);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            count <= '0;
        end else if (o_tick) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

/* hdl/i2c_txn_sequencer.sv */
`timescale 1ns/1ps
`include "i2c_params.svh"

module i2c_txn_sequencer
    import i2c_pkg::*;
(
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_tick,
    input  logic                       i_enable,
    input  logic                       i_rw,
    input  logic [`I2C_ADDR_WIDTH-1:0] i_device_addr,
    input  logic [`I2C_BYTE_WIDTH-1:0] i_reg_addr,
    input  logic [`I2C_BYTE_WIDTH-1:0] i_mosi_data,
    input  logic                       i_done,
    input  logic                       i_rx_bit,
    output logic                       o_cmd_valid,
    output i2c_cmd_e                   o_cmd,
    output logic                       o_tx_bit,
    output logic [`I2C_BYTE_WIDTH-1:0] o_miso_data,
    output logic                       o_busy
);

    localparam int BW    = `I2C_BYTE_WIDTH;
    localparam int CNT_W = $clog2(BW + 1);

    i2c_txn_state_e state;
    i2c_txn_state_e after_ack; // where a good ack leads
    i2c_addr_byte_u addr_byte;

    logic [BW-1:0]    reg_q;
    logic [BW-1:0]    data_q;
    logic             rw_q;
    logic [BW-1:0]    shift;
    logic [CNT_W-1:0] bit_cnt;
    logic             pending; // command in flight

    i2c_cmd_e next_cmd;
    logic     next_tx;

    // ============================================================
    // command for the current state
    // ============================================================
    always_comb begin
        next_cmd = CMD_WRITE_BIT;
        next_tx  = shift[BW-1]; // msb first
        case (state)
            START:   next_cmd = CMD_START;
            RESTART: next_cmd = CMD_RESTART;
            STOP:    next_cmd = CMD_STOP;
            ACK:     next_cmd = CMD_READ_BIT;
            RDATA: begin
                if (bit_cnt == CNT_W'(BW)) begin
                    next_tx = 1'b1; // nack after the only byte
                end else begin
                    next_cmd = CMD_READ_BIT;
                end
            end
            default: ;
        endcase
    end

    // ============================================================
    // transaction FSM
    // ============================================================
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state       <= IDLE;
            after_ack   <= IDLE;
            pending     <= 1'b0;
            bit_cnt     <= '0;
            o_cmd_valid <= 1'b0;
            o_cmd       <= CMD_START;
            o_tx_bit    <= 1'b1;
            o_miso_data <= '0;
            o_busy      <= 1'b0;
        end else begin
            o_cmd_valid <= 1'b0;

            if (state == IDLE) begin
                if (i_tick && i_enable) begin
                    addr_byte.f.dev_addr <= i_device_addr;
                    addr_byte.f.rw       <= 1'b0;
                    reg_q                <= i_reg_addr;
                    data_q               <= i_mosi_data;
                    rw_q                 <= i_rw;
                    o_busy               <= 1'b1;
                    state                <= START;
                end
            end else if (!pending) begin
                o_cmd_valid <= 1'b1;
                o_cmd       <= next_cmd;
                o_tx_bit    <= next_tx;
                pending     <= 1'b1;
            end else if (i_done) begin
                pending <= 1'b0;
                case (state)
                    START, RESTART: begin
                        shift   <= addr_byte.raw;
                        bit_cnt <= '0;
                        state   <= (state == START) ? DEV_W : DEV_R;
                    end

                    DEV_W, REG, DEV_R, WDATA: begin
                        shift <= shift << 1;
                        if (bit_cnt == CNT_W'(BW - 1)) begin
                            bit_cnt <= '0;
                            state   <= ACK;
                            case (state)
                                DEV_W: after_ack <= REG;
                                REG: begin
                                    after_ack      <= rw_q ? RESTART : WDATA;
                                    addr_byte.f.rw <= rw_q;
                                end
                                DEV_R:   after_ack <= RDATA;
                                default: after_ack <= STOP;
                            endcase
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end

                    ACK: begin
                        if (i_rx_bit) begin // no ack, abort without stop
                            state  <= IDLE;
                            o_busy <= 1'b0;
                        end else begin
                            state <= after_ack;
                            case (after_ack)
                                REG:     shift <= reg_q;
                                WDATA:   shift <= data_q;
                                default: ;
                            endcase
                        end
                    end

                    RDATA: begin
                        if (bit_cnt == CNT_W'(BW)) begin
                            bit_cnt <= '0;
                            state   <= STOP;
                        end else begin
                            o_miso_data <= {o_miso_data[BW-2:0], i_rx_bit};
                            bit_cnt     <= bit_cnt + 1'b1;
                        end
                    end

                    default: begin // STOP
                        state  <= IDLE;
                        o_busy <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

/* tests/i2c_master_sva.sv */
`timescale 1ns/1ps

module i2c_master_sva
    import i2c_pkg::*;
(
    input logic           i_clk,
    input logic           i_rst,
    input logic           i_busy,
    input logic           i_scl,
    input logic           i_sda,
    input i2c_txn_state_e i_state
);

    int fail_count = 0;

    // ============================================================
    // bus protocol
    // ============================================================

    // sda only moves under a high scl for start, restart or stop
    sda_stable_a: assert property (
        @(posedge i_clk) disable iff (i_rst)
        ($changed(i_sda) && i_scl && $past(i_scl))
            |-> (i_busy && (i_state inside {START, RESTART, STOP}))
    ) else begin
        $error("sda moved while scl was high outside a start or stop");
        fail_count++;
    end

    reset_idle_a: assert property (
        @(posedge i_clk) i_rst |=> (i_scl && i_sda && !i_busy)
    ) else begin
        $error("lines not released or busy set after reset");
        fail_count++;
    end

    // sda is left released when busy ends from a stop or a missing ack
    busy_end_a: assert property (
        @(posedge i_clk) disable iff (i_rst)
        $fell(i_busy) |-> i_sda
            && (($past(i_state) == STOP && i_scl) || $past(i_state) == ACK)
    ) else begin
        $error("busy dropped without a finished stop or a missing ack");
        fail_count++;
    end

endmodule

bind i2c_master_top i2c_master_sva u_sva (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_busy  (o_busy),
    .i_scl   (io_scl),
    .i_sda   (io_sda),
    .i_state (u_seq.state)
);

/* tests/i2c_slave_model.sv */
`timescale 1ns/1ps
`include "i2c_params.svh"

module i2c_slave_model
    import i2c_pkg::*;
#(
    parameter logic [`I2C_ADDR_WIDTH-1:0] DEV_ADDR   = 7'h50,
    parameter int                         STRETCH_NS = 500
) (
    input  logic i_stretch,
    inout  wire  io_scl,
    inout  wire  io_sda
);

    localparam int BW = `I2C_BYTE_WIDTH;

    typedef enum {M_IDLE, M_ADDR, M_REG, M_WDATA, M_TX} mode_e;

    logic [BW-1:0]  mem [256];
    mode_e          mode;
    mode_e          next_mode; // mode after the ack clock
    logic [BW-1:0]  shreg;
    logic [BW-1:0]  tx;
    logic [BW-1:0]  ptr;
    int             bit_cnt;   // scl rises seen in this byte frame
    logic           nack;
    logic           sda_low;
    logic           scl_low;
    i2c_addr_byte_u first;

    assign io_scl = scl_low ? 1'b0 : 1'bz;
    assign io_sda = sda_low ? 1'b0 : 1'bz;

    initial begin
        mode      = M_IDLE;
        next_mode = M_IDLE;
        bit_cnt   = 0;
        nack      = 1'b0;
        ptr       = '0;
        sda_low   = 1'b0;
        scl_low   = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i) ^ 8'ha5;
        end
    end

    // byte complete, decide on the ack
    task automatic accept_byte();
        case (mode)
            M_ADDR: begin
                first.raw = shreg;
                if (first.f.dev_addr == DEV_ADDR) begin
                    sda_low   = 1'b1;
                    next_mode = first.f.rw ? M_TX : M_REG;
                end else begin
                    mode = M_IDLE; // not ours, stay off the bus
                end
            end
            M_REG: begin
                ptr       = shreg;
                sda_low   = 1'b1;
                next_mode = M_WDATA;
            end
            default: begin
                mem[ptr]  = shreg;
                sda_low   = 1'b1;
                next_mode = M_WDATA;
            end
        endcase
    endtask

    // ============================================================
    // start, repeated start and stop
    // ============================================================
    always @(negedge io_sda) begin
        if (io_scl === 1'b1) begin
            mode    = M_ADDR;
            bit_cnt = 0;
            sda_low = 1'b0;
        end
    end

    always @(posedge io_sda) begin
        if (io_scl === 1'b1) begin
            mode = M_IDLE; // stop
        end
    end

    // ============================================================
    // bit level
    // ============================================================
    always @(posedge io_scl) begin
        if (mode != M_IDLE) begin
            if (bit_cnt < BW && mode != M_TX) begin
                shreg = {shreg[BW-2:0], io_sda};
            end
            if (bit_cnt == BW && mode == M_TX) begin
                nack = io_sda; // master ack after our byte
            end
            bit_cnt = bit_cnt + 1;
        end
    end

    always @(negedge io_scl) begin
        if (mode != M_IDLE) begin
            if (bit_cnt == BW) begin
                if (mode == M_TX) begin
                    sda_low = 1'b0; // let the master answer
                end else begin
                    accept_byte();
                end
            end else if (bit_cnt == BW + 1) begin
                sda_low = 1'b0;
                bit_cnt = 0;
                if (mode == M_TX && nack) begin
                    mode = M_IDLE;
                end else begin
                    mode = next_mode;
                end
                if (mode == M_TX) begin
                    tx      = mem[ptr];
                    sda_low = ~tx[BW-1];
                end
            end else if (mode == M_TX && bit_cnt > 0) begin
                sda_low = ~tx[BW-1-bit_cnt];
            end
        end
    end

    // hold scl low a while after every fall of a bit we take part in
    always @(negedge io_scl) begin
        if (i_stretch && mode != M_IDLE) begin
            scl_low = 1'b1;
            #(STRETCH_NS);
            scl_low = 1'b0;
        end
    end

endmodule

/* tests/tb_i2c_master.sv */
`timescale 1ns/1ps
`include "i2c_params.svh"

module tb_i2c_master;

    localparam logic [`I2C_ADDR_WIDTH-1:0] SLAVE_ADDR = 7'h50;
    localparam int TIMEOUT_CYCLES = 5 * 2000; // five tests, a stretched read is well below 2000

    logic                       clk;
    logic                       rst;
    logic                       enable;
    logic                       rw;
    logic [`I2C_ADDR_WIDTH-1:0] device_addr;
    logic [`I2C_BYTE_WIDTH-1:0] reg_addr;
    logic [`I2C_BYTE_WIDTH-1:0] mosi_data;
    logic [`I2C_DIV_WIDTH-1:0]  divider;
    logic [`I2C_BYTE_WIDTH-1:0] miso_data;
    logic                       busy;
    logic                       stretch;
    wire                        scl;
    wire                        sda;

    int pass_cnt = 0;
    int fail_cnt = 0;

    pullup (scl);
    pullup (sda);

    i2c_master_top DUT (
        .i_clk         (clk),
        .i_rst         (rst),
        .i_enable      (enable),
        .i_rw          (rw),
        .i_device_addr (device_addr),
        .i_reg_addr    (reg_addr),
        .i_mosi_data   (mosi_data),
        .i_divider     (divider),
        .o_miso_data   (miso_data),
        .o_busy        (busy),
        .io_scl        (scl),
        .io_sda        (sda)
    );

    i2c_slave_model #(.DEV_ADDR(SLAVE_ADDR)) u_slave (
        .i_stretch (stretch),
        .io_scl    (scl),
        .io_sda    (sda)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        assert (act === exp) begin
            $display("ok     %s: %0h", name, act);
            pass_cnt++;
        end else begin
            $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
            fail_cnt++;
        end
    endtask

    // one request, held a few cycles into busy, then wait for the end
    task automatic run_transfer(input logic do_read, input logic [6:0] dev,
                                input logic [7:0] reg_a, input logic [7:0] data);
        @(negedge clk);
        enable      = 1'b1;
        rw          = do_read;
        device_addr = dev;
        reg_addr    = reg_a;
        mosi_data   = data;
        do @(negedge clk); while (!busy);
        repeat (3) @(negedge clk);
        enable = 1'b0;
        do @(negedge clk); while (busy);
    endtask

    // ============================================================
    // stimulus
    // ============================================================
    initial begin
        logic [7:0] reg_a;
        logic [7:0] reg_b;
        logic [7:0] data_a;
        logic [7:0] data_b;

        rst         = 1'b1;
        enable      = 1'b0;
        rw          = 1'b0;
        device_addr = '0;
        reg_addr    = '0;
        mosi_data   = '0;
        divider     = 16'd4;
        stretch     = 1'b0;

        void'($urandom(32'h7c74_13cc));
        reg_a  = 8'($urandom);
        reg_b  = 8'($urandom);
        data_a = 8'($urandom);
        data_b = 8'($urandom);

        repeat (8) @(negedge clk);
        rst = 1'b0;

        run_transfer(1'b0, SLAVE_ADDR, reg_a, data_a);
        check_value("write", data_a, u_slave.mem[reg_a]);

        run_transfer(1'b1, SLAVE_ADDR, reg_a, 8'h00);
        check_value("read back", data_a, miso_data);

        run_transfer(1'b0, 7'h51, reg_a, ~data_a); // nobody acks, aborts
        check_value("wrong address", data_a, u_slave.mem[reg_a]);

        stretch = 1'b1;
        run_transfer(1'b0, SLAVE_ADDR, reg_b, data_b);
        run_transfer(1'b1, SLAVE_ADDR, reg_b, 8'h00);
        check_value("clock stretch", data_b, miso_data);

        check_value("bus protocol", 16'd0, 16'(DUT.u_sva.fail_count));

        $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, a transfer never finished", cycles);
        $display("TB FAILED");
        $finish;
    end

endmodule
